// File: hdl/blit_pkg.sv
`default_nettype none

package blit_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command and FSM encodings
  localparam logic [1:0] OP_CLEAR      = 2'd0;
  localparam logic [1:0] OP_BACKGROUND = 2'd1;

  localparam logic [2:0] ST_IDLE   = 3'd0;
  localparam logic [2:0] ST_CLEAR  = 3'd1;
  localparam logic [2:0] ST_FETCH  = 3'd2;
  localparam logic [2:0] ST_EXPAND = 3'd3;
  localparam logic [2:0] ST_FINISH = 3'd4;

  // ~~~~~~~~~~~~~~~~~~~~
  // Screen geometry
  localparam int SCREEN_W      = 320;
  localparam int SCREEN_H      = 240;
  localparam int PIXEL_COUNT   = SCREEN_W * SCREEN_H;
  localparam int TILE_W        = 8;
  localparam int TILES_PER_ROW = SCREEN_W / TILE_W;

  localparam int FLASH_WAIT = 3;                    // Cycles the flash needs before DQ is valid

  // Entry 15 is listed first, entry 0 last; bit 7 is the leftmost pixel
  localparam logic [15:0][7:0] TILE_PATTERNS = {
    8'h80, 8'h01, 8'hC3, 8'h3C, 8'hE7, 8'h18, 8'h7E, 8'h81,
    8'h33, 8'hCC, 8'h0F, 8'hF0, 8'h55, 8'hAA, 8'hFF, 8'h00
  };

  // RGB565 colors, again entry 15 first
  localparam logic [15:0][15:0] PALETTE = {
    16'hFFFF, 16'hC618, 16'h7BEF, 16'hF81F,
    16'h07FF, 16'hFFE0, 16'hF800, 16'h07E0,
    16'h001F, 16'hFD20, 16'h8010, 16'h0410,
    16'h8000, 16'h0400, 16'h0010, 16'h0000
  };

  localparam logic [15:0] BLACK = 16'h0000;

endpackage

`default_nettype wire

// File: hdl/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
  input  logic        clk,
  input  logic        reset,
  input  logic        rd_req,
  input  logic [22:0] rd_addr,
  output logic [7:0]  rd_data,
  output logic        rd_valid,
  input  logic [7:0]  FL_DQ,
  output logic [22:0] FL_ADDR,
  output logic        FL_CE_N,
  output logic        FL_OE_N,
  output logic        FL_WE_N,
  output logic        FL_RST_N,
  output logic        FL_WP_N
);

  logic       busy;                                 // A read cycle is on the pins
  logic [3:0] wait_cnt;                             // Cycles left before DQ is sampled
  logic       capture;

  assign capture = busy && (wait_cnt == 4'd0);

  // Only reads are done, so the write side of the chip stays parked
  assign FL_WE_N  = 1'b1;
  assign FL_RST_N = 1'b1;
  assign FL_WP_N  = 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~
  // Read cycle control
  always_ff @(posedge clk, negedge reset) begin
    if (!reset) begin
      busy     <= 1'b0;
      wait_cnt <= 4'd0;
      rd_valid <= 1'b0;
      FL_CE_N  <= 1'b1;
      FL_OE_N  <= 1'b1;
    end else begin
      rd_valid <= 1'b0;
      if (rd_req && !busy) begin
        busy     <= 1'b1;
        wait_cnt <= 4'(blit_pkg::FLASH_WAIT - 1);
        FL_CE_N  <= 1'b0;
        FL_OE_N  <= 1'b0;
      end else if (capture) begin
        busy     <= 1'b0;                           // Byte is taken on this edge
        FL_CE_N  <= 1'b1;
        FL_OE_N  <= 1'b1;
        rd_valid <= 1'b1;
      end else if (busy) begin
        wait_cnt <= wait_cnt - 4'd1;
      end
    end
  end

  // Address and data registers
  always_ff @(posedge clk) begin
    if (rd_req && !busy) begin
      FL_ADDR <= rd_addr;
    end
    if (capture) begin
      rd_data <= FL_DQ;
    end
  end

endmodule

`default_nettype wire

// File: hdl/blit_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module blit_sequencer (
  input  logic        clk,
  input  logic        reset,
  input  logic [1:0]  opcode,
  input  logic [22:0] start_address,
  input  logic [22:0] end_address,
  input  logic        draw_en,
  output logic        draw_complete,
  output logic        rd_req,
  output logic [22:0] rd_addr,
  input  logic        rd_valid,
  output logic        tile_load,
  output logic [8:0]  tile_x,
  output logic [7:0]  tile_y,
  input  logic        tile_done,
  input  logic        exp_valid,
  input  logic [8:0]  exp_x,
  input  logic [7:0]  exp_y,
  input  logic [15:0] exp_color,
  output logic        pix_valid,
  output logic [8:0]  pix_x,
  output logic [7:0]  pix_y,
  output logic [15:0] pix_color
);

  logic [2:0]  state;
  logic [22:0] flash_addr;                          // Next byte to fetch
  logic [22:0] end_addr_q;
  logic        last_tile;                           // Byte being expanded is the final one
  logic        rd_issued;                           // Flash read outstanding
  logic [5:0]  slot_col;
  logic [7:0]  slot_row;
  logic [8:0]  clr_x;
  logic [7:0]  clr_y;
  logic [16:0] clr_count;
  logic        clearing;

  assign clearing = (state == blit_pkg::ST_CLEAR);

  // The next read goes out in the same cycle as tile_done, which keeps a
  // tile at FLASH_WAIT + 1 + 8 cycles
  assign rd_req  = !rd_issued && ((state == blit_pkg::ST_FETCH) ||
                   (state == blit_pkg::ST_EXPAND && tile_done && !last_tile));
  assign rd_addr = flash_addr;

  assign tile_load = rd_valid;                      // Byte goes straight to the expander
  assign tile_x    = 9'(slot_col * blit_pkg::TILE_W);
  assign tile_y    = slot_row;

  // ~~~~~~~~~~~~~~~~~~~~
  // Pixel source mux
  assign pix_valid = clearing || exp_valid;
  assign pix_x     = clearing ? clr_x : exp_x;
  assign pix_y     = clearing ? clr_y : exp_y;
  assign pix_color = clearing ? blit_pkg::BLACK : exp_color;

  // ~~~~~~~~~~~~~~~~~~~~
  // Command FSM
  always_ff @(posedge clk, negedge reset) begin
    if (!reset) begin
      state         <= blit_pkg::ST_IDLE;
      draw_complete <= 1'b0;
      rd_issued     <= 1'b0;
      last_tile     <= 1'b0;
      slot_col      <= 6'd0;
      slot_row      <= 8'd0;
      clr_x         <= 9'd0;
      clr_y         <= 8'd0;
      clr_count     <= 17'd0;
    end else begin
      draw_complete <= 1'b0;
      if (rd_req) begin
        rd_issued <= 1'b1;
      end else if (rd_valid) begin
        rd_issued <= 1'b0;
      end

      case (state)
        blit_pkg::ST_IDLE: begin
          if (draw_en) begin
            slot_col  <= 6'd0;
            slot_row  <= 8'd0;
            clr_x     <= 9'd0;
            clr_y     <= 8'd0;
            clr_count <= 17'd0;
            case (opcode)
              blit_pkg::OP_CLEAR:      state <= blit_pkg::ST_CLEAR;
              blit_pkg::OP_BACKGROUND: state <= blit_pkg::ST_FETCH;
              default:                 draw_complete <= 1'b1;    // Nothing to draw
            endcase
          end
        end
        blit_pkg::ST_CLEAR: begin
          clr_count <= clr_count + 17'd1;
          if (clr_x == 9'(blit_pkg::SCREEN_W - 1)) begin
            clr_x <= 9'd0;
            clr_y <= clr_y + 8'd1;
          end else begin
            clr_x <= clr_x + 9'd1;
          end
          if (clr_count == 17'(blit_pkg::PIXEL_COUNT - 1)) begin
            state <= blit_pkg::ST_FINISH;
          end
        end
        blit_pkg::ST_FETCH: begin
          if (rd_valid) begin
            last_tile <= (flash_addr == end_addr_q);
            state     <= blit_pkg::ST_EXPAND;
          end
        end
        blit_pkg::ST_EXPAND: begin
          if (tile_done) begin
            if (slot_col == 6'(blit_pkg::TILES_PER_ROW - 1)) begin
              slot_col <= 6'd0;                     // Wrap to the next tile row
              slot_row <= slot_row + 8'd1;
            end else begin
              slot_col <= slot_col + 6'd1;
            end
            state <= last_tile ? blit_pkg::ST_FINISH : blit_pkg::ST_FETCH;
          end
        end
        blit_pkg::ST_FINISH: begin
          draw_complete <= 1'b1;                    // Final SRAM write is on the pins now
          state         <= blit_pkg::ST_IDLE;
        end
        default: state <= blit_pkg::ST_IDLE;
      endcase
    end
  end

  // Command addresses
  always_ff @(posedge clk) begin
    if (state == blit_pkg::ST_IDLE && draw_en) begin
      flash_addr <= start_address;
      end_addr_q <= end_address;
    end else if (state == blit_pkg::ST_FETCH && rd_valid) begin
      flash_addr <= flash_addr + 23'd1;
    end
  end

endmodule

`default_nettype wire

// File: hdl/tile_expander.sv
`timescale 1ns/1ps
`default_nettype none

module tile_expander (
  input  logic        clk,
  input  logic        reset,
  input  logic        tile_load,
  input  logic [7:0]  tile_code,
  input  logic [8:0]  tile_x,
  input  logic [7:0]  tile_y,
  output logic        exp_valid,
  output logic [8:0]  exp_x,
  output logic [7:0]  exp_y,
  output logic [15:0] exp_color,
  output logic        tile_done
);

  logic        active;
  logic [2:0]  pix_cnt;                             // Pixel index inside the tile
  logic [7:0]  pattern_q;                           // Shifts left, bit 7 is the current pixel
  logic [15:0] color_q;
  logic [8:0]  base_x;
  logic [7:0]  base_y;

  assign exp_valid = active;
  assign exp_x     = base_x + 9'(pix_cnt);
  assign exp_y     = base_y;
  assign exp_color = pattern_q[7] ? color_q : blit_pkg::BLACK;
  assign tile_done = active && (pix_cnt == 3'd7);

  always_ff @(posedge clk, negedge reset) begin
    if (!reset) begin
      active  <= 1'b0;
      pix_cnt <= 3'd0;
    end else if (tile_load) begin
      active  <= 1'b1;
      pix_cnt <= 3'd0;
    end else if (active) begin
      pix_cnt <= pix_cnt + 3'd1;
      if (pix_cnt == 3'd7) begin
        active <= 1'b0;
      end
    end
  end

  // Tile lookup, low nibble is the pattern and high nibble the color
  always_ff @(posedge clk) begin
    if (tile_load) begin
      pattern_q <= blit_pkg::TILE_PATTERNS[tile_code[3:0]];
      color_q   <= blit_pkg::PALETTE[tile_code[7:4]];
      base_x    <= tile_x;
      base_y    <= tile_y;
    end else if (active) begin
      pattern_q <= {pattern_q[6:0], 1'b0};
    end
  end

endmodule

`default_nettype wire

// File: hdl/sram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module sram_writer (
  input  logic        clk,
  input  logic        reset,
  input  logic        pix_valid,
  input  logic [8:0]  pix_x,
  input  logic [7:0]  pix_y,
  input  logic [15:0] pix_color,
  output logic [15:0] SRAM_DQ,
  output logic [19:0] SRAM_ADDR,
  output logic        SRAM_UB_N,
  output logic        SRAM_LB_N,
  output logic        SRAM_CE_N,
  output logic        SRAM_OE_N,
  output logic        SRAM_WE_N
);

  logic [19:0] pix_addr;

  // Row-major frame buffer, one word per pixel
  assign pix_addr = 20'(pix_y) * 20'(blit_pkg::SCREEN_W) + 20'(pix_x);

  // Writes are always full words and the SRAM is never read
  assign SRAM_UB_N = 1'b0;
  assign SRAM_LB_N = 1'b0;
  assign SRAM_OE_N = 1'b1;

  // ~~~~~~~~~~~~~~~~~~~~
  // Write strobes, one cycle per pixel
  always_ff @(posedge clk, negedge reset) begin
    if (!reset) begin
      SRAM_WE_N <= 1'b1;
      SRAM_CE_N <= 1'b1;
    end else begin
      SRAM_WE_N <= !pix_valid;
      SRAM_CE_N <= !pix_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pix_valid) begin
      SRAM_ADDR <= pix_addr;
      SRAM_DQ   <= pix_color;
    end
  end

endmodule

`default_nettype wire

// File: hdl/blitter_top.sv
`timescale 1ns/1ps
`default_nettype none

module blitter_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [1:0]  opcode,
  input  logic [22:0] start_address,
  input  logic [22:0] end_address,
  input  logic        draw_en,
  output logic        draw_complete,
  input  logic [7:0]  FL_DQ,
  output logic [22:0] FL_ADDR,
  output logic        FL_CE_N,
  output logic        FL_OE_N,
  output logic        FL_WE_N,
  output logic        FL_RST_N,
  output logic        FL_WP_N,
  output logic [15:0] SRAM_DQ,
  output logic [19:0] SRAM_ADDR,
  output logic        SRAM_UB_N,
  output logic        SRAM_LB_N,
  output logic        SRAM_CE_N,
  output logic        SRAM_OE_N,
  output logic        SRAM_WE_N
);

  // ~~~~~~~~~~~~~~~~~~~~
  // Flash read path
  logic        rd_req;
  logic [22:0] rd_addr;
  logic [7:0]  rd_data;
  logic        rd_valid;

  // Tile path
  logic        tile_load;
  logic [8:0]  tile_x;
  logic [7:0]  tile_y;
  logic        tile_done;
  logic        exp_valid;
  logic [8:0]  exp_x;
  logic [7:0]  exp_y;
  logic [15:0] exp_color;

  // Pixel path
  logic        pix_valid;
  logic [8:0]  pix_x;
  logic [7:0]  pix_y;
  logic [15:0] pix_color;

  flash_reader u_flash_reader (
    .clk, .reset, .rd_req, .rd_addr, .rd_data, .rd_valid,
    .FL_DQ, .FL_ADDR, .FL_CE_N, .FL_OE_N, .FL_WE_N, .FL_RST_N, .FL_WP_N
  );

  blit_sequencer u_blit_sequencer (
    .clk, .reset, .opcode, .start_address, .end_address, .draw_en, .draw_complete,
    .rd_req, .rd_addr, .rd_valid,
    .tile_load, .tile_x, .tile_y, .tile_done,
    .exp_valid, .exp_x, .exp_y, .exp_color,
    .pix_valid, .pix_x, .pix_y, .pix_color
  );

  tile_expander u_tile_expander (
    .clk, .reset, .tile_load,
    .tile_code (rd_data),                           // Flash byte is the tile code
    .tile_x, .tile_y,
    .exp_valid, .exp_x, .exp_y, .exp_color, .tile_done
  );

  sram_writer u_sram_writer (
    .clk, .reset, .pix_valid, .pix_x, .pix_y, .pix_color,
    .SRAM_DQ, .SRAM_ADDR, .SRAM_UB_N, .SRAM_LB_N, .SRAM_CE_N, .SRAM_OE_N, .SRAM_WE_N
  );

endmodule

`default_nettype wire

// File: sim/clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;                         // 100 ns period
  end

  initial begin
    reset = 1'b1;
    #1 reset = 1'b0;                                // Clean falling edge for the async reset
    repeat (4) @(posedge clk);
    reset <= 1'b1;
  end

endmodule

`default_nettype wire

// File: sim/blitter_checker.sv
`timescale 1ns/1ps
`default_nettype none

module blitter_checker (
  input logic clk,
  input logic reset,
  input logic draw_complete,
  input logic fl_oe_n,
  input logic sram_ce_n,
  input logic sram_oe_n,
  input logic sram_we_n
);

  // ~~~~~~~~~~~~~~~~~~~~
  // SRAM strobes
  we_with_ce: assert property (@(posedge clk) disable iff (!reset) !sram_we_n |-> !sram_ce_n)
    else $error("SRAM write strobe seen without chip enable");

  // ~~~~~~~~~~~~~~~~~~~~
  // Completion and reset state
  complete_pulse: assert property (@(posedge clk) disable iff (!reset)
    draw_complete |=> !draw_complete)
    else $error("draw_complete stayed high for more than one cycle");

  idle_after_reset: assert property (@(posedge clk) $rose(reset) |-> fl_oe_n && sram_oe_n)
    else $error("Output enables were not parked high when reset was released");

endmodule

bind blitter_top blitter_checker u_checker (
  .clk           (clk),
  .reset         (reset),
  .draw_complete (draw_complete),
  .fl_oe_n       (FL_OE_N),
  .sram_ce_n     (SRAM_CE_N),
  .sram_oe_n     (SRAM_OE_N),
  .sram_we_n     (SRAM_WE_N)
);

`default_nettype wire

// File: sim/tb_blitter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_blitter;

  localparam int MAX_CMDS = 32;
  localparam int NPIX     = blit_pkg::PIXEL_COUNT;

  logic        clk;
  logic        reset;
  logic [1:0]  opcode;
  logic [22:0] start_address;
  logic [22:0] end_address;
  logic        draw_en;
  logic        draw_complete;
  logic [7:0]  fl_dq;
  logic [22:0] fl_addr;
  logic        fl_ce_n;
  logic        fl_oe_n;
  logic        fl_we_n;
  logic        fl_rst_n;
  logic        fl_wp_n;
  logic [15:0] sram_dq;
  logic [19:0] sram_addr;
  logic        sram_ub_n;
  logic        sram_lb_n;
  logic        sram_ce_n;
  logic        sram_oe_n;
  logic        sram_we_n;

  logic [7:0]  flash_mem [65536];
  logic [15:0] sram_mem [NPIX];                     // What the DUT wrote
  logic [15:0] ref_mem [NPIX];                      // What the frame should hold
  int          write_count [NPIX];
  bit          covered [NPIX];                      // Pixel belongs to the current command
  logic [31:0] vec_mem [3 * MAX_CMDS];

  int seed = 16313;
  int error_count = 0;
  int cycle_count = 0;
  int watchdog_cycles = 0;
  int cmd_writes;
  int complete_count;
  int complete_cycle;
  int last_write_cycle;

  clock_gen u_clock_gen (.clk, .reset);

  blitter_top dut (
    .clk, .reset, .opcode, .start_address, .end_address, .draw_en, .draw_complete,
    .FL_DQ (fl_dq), .FL_ADDR (fl_addr), .FL_CE_N (fl_ce_n), .FL_OE_N (fl_oe_n),
    .FL_WE_N (fl_we_n), .FL_RST_N (fl_rst_n), .FL_WP_N (fl_wp_n),
    .SRAM_DQ (sram_dq), .SRAM_ADDR (sram_addr), .SRAM_UB_N (sram_ub_n),
    .SRAM_LB_N (sram_lb_n), .SRAM_CE_N (sram_ce_n), .SRAM_OE_N (sram_oe_n),
    .SRAM_WE_N (sram_we_n)
  );

  // Flash model drives the byte only while the chip is read
  assign fl_dq = (!fl_ce_n && !fl_oe_n) ? flash_mem[fl_addr[15:0]] : 8'hFF;

  function automatic logic [15:0] fill_word(input int a);
    logic [16:0] w;
    w = 17'(a);
    return 16'(w ^ (w >> 1));                       // Gray code of the full address
  endfunction

  function automatic int tile_count(input logic [22:0] first, input logic [22:0] last);
    return int'(last - first) + 1;
  endfunction

  task automatic report_mismatch(input string name, input int got, input int expected);
    error_count++;
    if (error_count <= 20) $display("Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
  endtask

  task automatic report_problem(input string what);
    error_count++;
    if (error_count <= 20) $display("Failure: %s", what);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // SRAM model and bus sampling, called once per rising edge
  task automatic sample_edge();
    int a;
    @(posedge clk);
    cycle_count++;
    if (!sram_we_n) begin
      a = int'(sram_addr);
      assert (a < NPIX) else report_problem($sformatf("SRAM write past the frame at 0x%05h", a));
      assert (!sram_ub_n && !sram_lb_n)
        else report_problem("SRAM write without both byte lanes enabled");
      if (a < NPIX) begin
        sram_mem[a] = sram_dq;
        write_count[a]++;
      end
      cmd_writes++;
      last_write_cycle = cycle_count;
    end
    if (draw_complete) begin
      complete_count++;
      complete_cycle = cycle_count;
    end
  endtask

  task automatic apply_background(input logic [22:0] first, input logic [22:0] last);
    int k;
    int i;
    int a;
    logic [7:0] code;
    logic [7:0] pattern;
    for (k = 0; k < tile_count(first, last); k++) begin
      code    = flash_mem[16'(first + 23'(k))];
      pattern = blit_pkg::TILE_PATTERNS[code[3:0]];
      for (i = 0; i < blit_pkg::TILE_W; i++) begin
        a = (k / blit_pkg::TILES_PER_ROW) * blit_pkg::SCREEN_W +
            (k % blit_pkg::TILES_PER_ROW) * blit_pkg::TILE_W + i;
        ref_mem[a] = pattern[7 - i] ? blit_pkg::PALETTE[code[7:4]] : blit_pkg::BLACK;
        covered[a] = 1'b1;
      end
    end
  endtask

  task automatic compare_frame();
    int a;
    for (a = 0; a < NPIX; a++) begin
      assert (sram_mem[a] == ref_mem[a])
        else report_mismatch($sformatf("SRAM_DQ at 0x%05h", a), int'(sram_mem[a]),
                             int'(ref_mem[a]));
      assert (write_count[a] == (covered[a] ? 1 : 0))
        else report_mismatch($sformatf("SRAM_WE_N count at 0x%05h", a), write_count[a],
                             covered[a] ? 1 : 0);
    end
  endtask

  task automatic run_command(input logic [1:0] op, input logic [22:0] first,
                             input logic [22:0] last);
    int a;
    int en_cycle;
    int expected_writes;
    bit drawing;
    drawing = (op == blit_pkg::OP_CLEAR) || (op == blit_pkg::OP_BACKGROUND);
    for (a = 0; a < NPIX; a++) begin
      write_count[a] = 0;
      covered[a]     = 1'b0;
    end
    cmd_writes       = 0;
    complete_count   = 0;
    complete_cycle   = -1;
    last_write_cycle = -1;
    opcode        <= op;
    start_address <= first;
    end_address   <= last;
    draw_en       <= 1'b1;
    sample_edge();
    en_cycle = cycle_count;                         // Edge where the DUT takes the command
    draw_en <= 1'b0;
    if (drawing) begin
      repeat (4) sample_edge();
      opcode  <= blit_pkg::OP_CLEAR;                // A second request while busy
      draw_en <= 1'b1;
      sample_edge();
      opcode  <= op;
      draw_en <= 1'b0;
    end
    while (complete_count == 0) sample_edge();
    repeat (16) sample_edge();                      // Catches late writes or a second pulse

    if (op == blit_pkg::OP_CLEAR) begin
      for (a = 0; a < NPIX; a++) begin
        ref_mem[a] = blit_pkg::BLACK;
        covered[a] = 1'b1;
      end
      expected_writes = NPIX;
    end else if (op == blit_pkg::OP_BACKGROUND) begin
      apply_background(first, last);
      expected_writes = blit_pkg::TILE_W * tile_count(first, last);
    end else begin
      expected_writes = 0;
    end

    assert (complete_count == 1) else report_mismatch("draw_complete pulses", complete_count, 1);
    assert (cmd_writes == expected_writes)
      else report_mismatch("SRAM_WE_N writes", cmd_writes, expected_writes);
    if (drawing) begin
      assert (complete_cycle == last_write_cycle + 1)
        else report_mismatch("draw_complete cycle", complete_cycle, last_write_cycle + 1);
    end else begin
      assert (complete_cycle == en_cycle + 1)
        else report_mismatch("draw_complete cycle", complete_cycle, en_cycle + 1);
    end
    compare_frame();
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // Watchdog
  initial begin : watchdog
    wait (watchdog_cycles != 0);
    repeat (watchdog_cycles) @(posedge clk);
    $display("Timeout: the commands did not finish within %0d cycles", watchdog_cycles);
    $display("TEST FAIL");
    $finish;
  end

  initial begin : stimulus
    int i;
    int n_cmds;
    int clears;
    int tiles;
    opcode        = 2'd0;
    start_address = 23'd0;
    end_address   = 23'd0;
    draw_en       = 1'b0;
    for (i = 0; i < 65536; i++) flash_mem[i] = 8'($random(seed));
    for (i = 0; i < NPIX; i++) begin
      sram_mem[i] = fill_word(i);
      ref_mem[i]  = fill_word(i);
    end
    for (i = 0; i < 3 * MAX_CMDS; i++) vec_mem[i] = 32'hFFFF_FFFF;
    $readmemh("sim/blitter_vectors.txt", vec_mem);

    n_cmds = 0;
    clears = 0;
    tiles  = 0;
    while (n_cmds < MAX_CMDS && vec_mem[3 * n_cmds] != 32'hFFFF_FFFF) begin
      if (vec_mem[3 * n_cmds][1:0] == blit_pkg::OP_CLEAR) begin
        clears++;
      end else if (vec_mem[3 * n_cmds][1:0] == blit_pkg::OP_BACKGROUND) begin
        tiles += tile_count(vec_mem[3 * n_cmds + 1][22:0], vec_mem[3 * n_cmds + 2][22:0]);
      end
      n_cmds++;
    end
    watchdog_cycles = blit_pkg::PIXEL_COUNT * clears + 12 * tiles + 1000;
    assert (n_cmds > 0) else report_problem("No commands were read from the vectors file");

    wait (reset === 1'b0);
    while (!reset) sample_edge();
    sample_edge();
    assert (!draw_complete && sram_we_n && sram_ce_n && fl_ce_n && fl_oe_n &&
            fl_we_n && fl_rst_n && fl_wp_n)
      else report_problem("Outputs are not idle after reset");

    for (i = 0; i < n_cmds; i++) begin
      run_command(vec_mem[3 * i][1:0], vec_mem[3 * i + 1][22:0], vec_mem[3 * i + 2][22:0]);
    end

    $display("Checks failed: %0d, commands run: %0d", error_count, n_cmds);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: blitter.f
hdl/blit_pkg.sv
hdl/flash_reader.sv
hdl/blit_sequencer.sv
hdl/tile_expander.sv
hdl/sram_writer.sv
hdl/blitter_top.sv
sim/clock_gen.sv
sim/blitter_checker.sv
sim/tb_blitter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the blitter testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_blitter -f blitter.f -o tb_blitter

./obj_dir/tb_blitter > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASS" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log" >&2
exit 1

// File: sim/blitter_vectors.txt
// Blitter commands, one per line, all fields in hex
// opcode  start_address  end_address
1 000100 000107
2 000000 000000
1 000200 000231
0 000000 000000
3 001234 005678
1 00fff8 010008
1 000400 0004a0
1 12abcd 12abd4
2 7fffff 000000
0 000000 000000
1 003000 003257
3 000000 000000
1 000777 000777
